// File: design/tsop_mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_mac_unit #(
	parameter int mul_stages = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              op_valid,
	input  tsop_pkg::mac_op_t op,
	output logic              op_ready,
	output logic              res_valid,
	output tsop_pkg::result_t res,
	input  logic              res_ready
);

	localparam int rw = tsop_pkg::result_width;
	localparam int ow = tsop_pkg::operand_width;

	// What one pipeline stage carries besides its valid bit
	typedef struct packed {
		tsop_pkg::mac_opcode_e opcode;
		logic                  final_op;
		logic signed [rw-1:0]  product;
		logic signed [ow-1:0]  addend;
	} stage_t;

	// Stages 0 to mul_stages-1 are the multiplier, stage mul_stages is write-back
	stage_t               stage_q [mul_stages+1];
	logic [mul_stages:0]  stage_valid_q;

	logic signed [rw-1:0]    feedback_q;
	logic signed [rw-1:0]    acc_q;
	logic                    pending_q;

	logic signed [rw-1:0]    mcand;
	logic signed [rw+ow-1:0] product_full;
	logic signed [rw-1:0]    addend_ext;
	logic signed [rw-1:0]    wb_value;
	stage_t                  wb;
	logic                    advance;
	logic                    issue;
	logic                    retire;

	assign wb = stage_q[mul_stages];

	////////////////////
	// Issue and stall
	////////////////////

	// The pipeline only freezes when a finished result cannot leave
	assign advance = !(stage_valid_q[mul_stages] && wb.final_op && !res_ready);

	// The feedback step waits until the input step has loaded the feedback register
	assign op_ready = advance &&
		!(op.opcode == tsop_pkg::op_mul_add_feedback && pending_q);

	assign issue  = op_valid && op_ready;
	assign retire = stage_valid_q[mul_stages] && advance;

	////////////////////
	// Multiplier
	////////////////////

	always_comb begin
		if (op.opcode == tsop_pkg::op_mul_add_feedback) begin
			mcand = feedback_q;
		end else begin
			mcand = op.multiplicand;
		end
		product_full = mcand * op.multiplier;
	end

	////////////////////
	// Write-back
	////////////////////

	assign addend_ext = wb.addend;

	always_comb begin
		case (wb.opcode)
			tsop_pkg::op_mul_add_input:    wb_value = wb.product + addend_ext;
			tsop_pkg::op_mul_add_feedback: wb_value = wb.product + addend_ext;
			tsop_pkg::op_sop_first:        wb_value = wb.product;
			default:                       wb_value = acc_q + wb.product;
		endcase
	end

	// Only the operation that completes a request is handed on
	assign res_valid = stage_valid_q[mul_stages] && wb.final_op;
	assign res.value = wb_value;
	assign res.mode  = (wb.opcode == tsop_pkg::op_mul_add_feedback) ?
		tsop_pkg::mode_trinomial : tsop_pkg::mode_sum_of_products;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stage_valid_q <= '0;
			pending_q     <= 1'b0;
		end else begin
			if (advance) begin
				stage_valid_q <= {stage_valid_q[mul_stages-1:0], issue};
			end
			// At most one input step is in flight, so set and clear never meet
			if (issue && op.opcode == tsop_pkg::op_mul_add_input) begin
				pending_q <= 1'b1;
			end else if (retire && wb.opcode == tsop_pkg::op_mul_add_input) begin
				pending_q <= 1'b0;
			end
		end
	end

	////////////////////
	// Datapath
	////////////////////

	always_ff @(posedge clk) begin
		if (advance) begin
			// Products wrap modulo 2^25 like the accumulator
			stage_q[0].opcode   <= op.opcode;
			stage_q[0].final_op <= op.final_op;
			stage_q[0].product  <= product_full[rw-1:0];
			stage_q[0].addend   <= op.addend;
			for (int i = 1; i <= mul_stages; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			case (wb.opcode)
				tsop_pkg::op_mul_add_input: feedback_q <= wb_value;
				tsop_pkg::op_sop_first:     acc_q      <= wb_value;
				tsop_pkg::op_sop_next:      acc_q      <= wb_value;
				default: begin
					// The feedback step leaves both registers alone
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/tsop_operand_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_operand_decoder (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  tsop_pkg::request_beat_t in_beat,
	output logic                    in_ready,
	output logic                    op_valid,
	output tsop_pkg::mac_op_t       op,
	input  logic                    op_ready
);

	// Idle holds no operation, the two issue states hold one on op
	typedef enum logic [1:0] {
		idle,
		issue_first,
		issue_feedback
	} dec_state_e;

	dec_state_e state_q;

	// Goes high on the first cycle after reset and then stays high
	logic started_q;

	// High while a sum-of-products run has taken beats but not its last one
	logic sop_active_q;

	tsop_pkg::mac_op_t                         op_q;
	tsop_pkg::mac_op_t                         load_op;
	logic signed [tsop_pkg::operand_width-1:0] c_q;

	logic accept;
	logic promote;

	////////////////////
	// Handshakes
	////////////////////

	// A held sum-of-products operation can be replaced in the cycle it leaves
	// An input step is always followed by its feedback step first
	assign in_ready = started_q && ((state_q == idle) ||
		(state_q == issue_first && op_ready && op_q.opcode != tsop_pkg::op_mul_add_input));

	assign accept   = in_valid && in_ready;
	assign op_valid = (state_q != idle);
	assign op       = op_q;

	// The input step has gone to the MAC unit, so the feedback step comes next
	assign promote  = (state_q == issue_first) && op_ready &&
		(op_q.opcode == tsop_pkg::op_mul_add_input);

	////////////////////
	// Beat expansion
	////////////////////

	always_comb begin
		load_op.multiplicand = in_beat.a;
		load_op.multiplier   = in_beat.x;
		if (in_beat.mode == tsop_pkg::mode_trinomial) begin
			// First Horner step a*x + b, the result goes to the feedback register
			load_op.opcode   = tsop_pkg::op_mul_add_input;
			load_op.addend   = in_beat.b;
			load_op.final_op = 1'b0;
		end else begin
			// Only a and x matter for a sum of products
			load_op.opcode   = sop_active_q ? tsop_pkg::op_sop_next : tsop_pkg::op_sop_first;
			load_op.addend   = '0;
			load_op.final_op = in_beat.last;
		end
	end

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q      <= idle;
			started_q    <= 1'b0;
			sop_active_q <= 1'b0;
		end else begin
			started_q <= 1'b1;
			if (accept && in_beat.mode == tsop_pkg::mode_sum_of_products) begin
				sop_active_q <= !in_beat.last;
			end
			case (state_q)
				idle: begin
					if (accept) begin
						state_q <= issue_first;
					end
				end
				issue_first: begin
					if (promote) begin
						state_q <= issue_feedback;
					end else if (op_ready && !accept) begin
						state_q <= idle;
					end
				end
				issue_feedback: begin
					// The MAC unit takes this only after the input step wrote back
					if (op_ready) begin
						state_q <= idle;
					end
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	// Operation payload, loaded from a beat or turned into the feedback step
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= load_op;
			c_q  <= in_beat.c;
		end else if (promote) begin
			// The multiplicand comes from the feedback register in the MAC unit
			op_q.opcode       <= tsop_pkg::op_mul_add_feedback;
			op_q.multiplicand <= '0;
			op_q.addend       <= c_q;
			op_q.final_op     <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/tsop_pkg.sv
`default_nettype none

package tsop_pkg;

	////////////////////
	// Widths
	////////////////////

	// Width of every request operand a, b, c and x
	localparam int operand_width = 8;

	// Width of a result, wide enough for a long sum of 16-bit products
	localparam int result_width = 25;

	////////////////////
	// Enums
	////////////////////

	// Which problem a request or a result belongs to
	typedef enum logic {
		mode_sum_of_products = 1'b0,
		mode_trinomial       = 1'b1
	} solve_mode_e;

	// Operations understood by the MAC unit
	// The two trinomial steps are (a*x + b) into the feedback register and
	// then (feedback*x + c) into the result
	typedef enum logic [1:0] {
		op_mul_add_input    = 2'b00,
		op_mul_add_feedback = 2'b01,
		op_sop_first        = 2'b10,
		op_sop_next         = 2'b11
	} mac_opcode_e;

	////////////////////
	// Structs
	////////////////////

	// One request beat as seen on the input handshake
	typedef struct packed {
		logic signed [operand_width-1:0] a;
		logic signed [operand_width-1:0] b;
		logic signed [operand_width-1:0] c;
		logic signed [operand_width-1:0] x;
		solve_mode_e                     mode;
		logic                            last;
	} request_beat_t;

	// One operation passed from the decoder to the MAC unit
	// The final flag marks the operation whose write-back completes a result
	typedef struct packed {
		mac_opcode_e                     opcode;
		logic signed [operand_width-1:0] multiplicand;
		logic signed [operand_width-1:0] multiplier;
		logic signed [operand_width-1:0] addend;
		logic                            final_op;
	} mac_op_t;

	// One finished result with the mode it came from
	typedef struct packed {
		logic signed [result_width-1:0] value;
		solve_mode_e                    mode;
	} result_t;

endpackage

`default_nettype wire

// File: design/tsop_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_result_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              res_valid,
	input  tsop_pkg::result_t res,
	output logic              res_ready,
	output logic              out_valid,
	output tsop_pkg::result_t out_result,
	input  logic              out_ready
);

	// Two entries cover one result in flight plus one late stall
	tsop_pkg::result_t mem_q [2];

	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic [1:0] count_q;
	logic       push;
	logic       pop;

	////////////////////
	// Handshakes
	////////////////////

	assign res_ready  = (count_q != 2'd2);
	assign out_valid  = (count_q != 2'd0);
	assign out_result = mem_q[rd_ptr_q];

	assign push = res_valid && res_ready;
	assign pop  = out_valid && out_ready;

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr_q <= !wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= !rd_ptr_q;
			end
			// Push and pop together keep the count where it is
			if (push && !pop) begin
				count_q <= count_q + 2'd1;
			end else if (pop && !push) begin
				count_q <= count_q - 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_q[wr_ptr_q] <= res;
		end
	end

endmodule

`default_nettype wire

// File: design/tsop_solver.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_solver #(
	parameter int mul_stages = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  tsop_pkg::request_beat_t in_beat,
	output logic                    in_ready,
	output logic                    out_valid,
	output tsop_pkg::result_t       out_result,
	input  logic                    out_ready
);

	// Decoder to MAC unit
	logic              op_valid;
	tsop_pkg::mac_op_t op;
	logic              op_ready;

	// MAC unit to result stage
	logic              res_valid;
	tsop_pkg::result_t res;
	logic              res_ready;

	////////////////////
	// Decode
	////////////////////

	tsop_operand_decoder decoder0 (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_beat  (in_beat),
		.in_ready (in_ready),
		.op_valid (op_valid),
		.op       (op),
		.op_ready (op_ready)
	);

	////////////////////
	// Execute
	////////////////////

	tsop_mac_unit #(
		.mul_stages (mul_stages)
	) mac0 (
		.clk       (clk),
		.reset     (reset),
		.op_valid  (op_valid),
		.op        (op),
		.op_ready  (op_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

	////////////////////
	// Result
	////////////////////

	tsop_result_stage result0 (
		.clk        (clk),
		.reset      (reset),
		.res_valid  (res_valid),
		.res        (res),
		.res_ready  (res_ready),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_ready  (out_ready)
	);

endmodule

`default_nettype wire

// File: files.f
design/tsop_pkg.sv
design/tsop_operand_decoder.sv
design/tsop_mac_unit.sv
design/tsop_result_stage.sv
design/tsop_solver.sv
tb/tsop_properties.sv
tb/tsop_checker.sv
tb/tsop_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f --top-module tsop_tb \
	-o tsop_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tsop_sim > sim.log 2>&1 \
	; grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
	|| grep -q ">>> PASS" sim.log \
	|| { echo "Simulation ended without a verdict, see sim.log"; exit 1; }

echo "Simulation passed"

// File: tb/tsop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_checker (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  logic                    in_ready,
	input  tsop_pkg::request_beat_t in_beat,
	input  logic                    out_valid,
	input  logic                    out_ready,
	input  tsop_pkg::result_t       out_result,
	output int                      checked_count,
	output int                      error_count
);

	// Expected results in request order, built from the accepted beats
	tsop_pkg::result_t exp_q [$];

	// Every value seen on the output, kept for the table comparison in the testbench
	logic signed [tsop_pkg::result_width-1:0] seen_value [256];

	// Running sum of the current sum-of-products run
	int acc;
	bit in_run;

	// Inputs change half a nanosecond after the rising edge, so the falling
	// edge sees exactly what the next rising edge will take
	always @(negedge clk) begin
		tsop_pkg::result_t exp;
		int                full;
		if (reset) begin
			checked_count = 0;
			error_count   = 0;
			acc           = 0;
			in_run        = 1'b0;
			exp_q.delete();
		end else begin
			if (in_valid && in_ready) begin
				if (in_beat.mode == tsop_pkg::mode_trinomial) begin
					// Horner form (a*x + b)*x + c
					full = (int'(in_beat.a) * int'(in_beat.x) + int'(in_beat.b)) *
						int'(in_beat.x) + int'(in_beat.c);
					exp.value = full[tsop_pkg::result_width-1:0];
					exp.mode  = tsop_pkg::mode_trinomial;
					exp_q.push_back(exp);
				end else begin
					// A new run starts from zero, nothing carries over
					if (!in_run) begin
						acc = 0;
					end
					acc    = acc + int'(in_beat.a) * int'(in_beat.x);
					in_run = 1'b1;
					if (in_beat.last) begin
						exp.value = acc[tsop_pkg::result_width-1:0];
						exp.mode  = tsop_pkg::mode_sum_of_products;
						exp_q.push_back(exp);
						in_run = 1'b0;
					end
				end
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Result %0d appeared with no request outstanding", checked_count);
					error_count = error_count + 1;
				end else begin
					exp = exp_q.pop_front();
					if (out_result != exp) begin
						$display("** Error at %0t: result %0d is %0d mode %0d, model says %0d mode %0d",
							$time, checked_count, out_result.value, out_result.mode,
							exp.value, exp.mode);
						error_count = error_count + 1;
					end else begin
						$display("Result %0d matches the model, value %0d mode %0d",
							checked_count, out_result.value, out_result.mode);
					end
				end
				seen_value[checked_count[7:0]] = out_result.value;
				checked_count = checked_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tsop_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_properties #(
	parameter int mul_stages = 2
) (
	input logic              clk,
	input logic              reset,
	input logic              op_valid,
	input tsop_pkg::mac_op_t op,
	input logic              op_ready,
	input logic              res_valid,
	input tsop_pkg::result_t res,
	input logic              res_ready
);

	// Advancing edges the last input step still needs before it has written back
	int steps_left_q;

	// The pipeline moves on every edge except while a finished result is held
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			steps_left_q <= 0;
		end else if (op_valid && op_ready && op.opcode == tsop_pkg::op_mul_add_input) begin
			steps_left_q <= mul_stages + 1;
		end else if (steps_left_q > 0 && !(res_valid && !res_ready)) begin
			steps_left_q <= steps_left_q - 1;
		end
	end

	// A held operation stays put until the MAC unit takes it
	assert property (@(posedge clk) disable iff (reset)
		op_valid && !op_ready |=> op_valid && $stable(op))
		else $error("operation changed while stalled");

	// A result waiting for the result stage stays put
	assert property (@(posedge clk) disable iff (reset)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else $error("result changed while stalled");

	// The feedback step never enters before the input step wrote back
	assert property (@(posedge clk) disable iff (reset)
		!(op_valid && op_ready && op.opcode == tsop_pkg::op_mul_add_feedback &&
		steps_left_q != 0))
		else $error("feedback step issued while the input step was still in flight");

endmodule

bind tsop_mac_unit tsop_properties #(
	.mul_stages (mul_stages)
) props0 (
	.clk       (clk),
	.reset     (reset),
	.op_valid  (op_valid),
	.op        (op),
	.op_ready  (op_ready),
	.res_valid (res_valid),
	.res       (res),
	.res_ready (res_ready)
);

`default_nettype wire

// File: tb/tsop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tsop_tb;

	localparam int num_rows     = 13;
	localparam int wait_limit   = 2000;
	localparam int stall_cycles = 20;

	logic                    clk;
	logic                    reset;
	logic                    in_valid;
	tsop_pkg::request_beat_t in_beat;
	logic                    in_ready;
	logic                    out_valid;
	tsop_pkg::result_t       out_result;
	logic                    out_ready;
	int                      checked_count;
	int                      error_count;

	// Stimulus table, one request per row
	tsop_pkg::request_beat_t row_beat [num_rows][16];
	tsop_pkg::solve_mode_e   row_mode [num_rows];
	int                      row_len [num_rows];
	bit                      row_chain [num_rows];
	bit                      row_stall [num_rows];
	int                      row_exp [num_rows];

	int seed;
	int stall_left;
	bit random_ready;
	bit saw_in_ready_low;
	bit timed_out;
	int table_errors;

	tsop_solver #(
		.mul_stages (2)
	) dut0 (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_beat    (in_beat),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_ready  (out_ready)
	);

	tsop_checker checker0 (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_beat       (in_beat),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_result    (out_result),
		.checked_count (checked_count),
		.error_count   (error_count)
	);

	always #2 clk = !clk;

	////////////////////
	// Consumer side
	////////////////////

	// Ready after a fixed stall goes random, otherwise it stays high
	// Stall settings are taken at the edge, before the main flow updates them
	always @(posedge clk) begin
		int rnd;
		bit hold;
		bit use_random;
		hold       = (stall_left > 0);
		use_random = random_ready;
		#0.5;
		if (hold) begin
			out_ready  = 1'b0;
			stall_left = stall_left - 1;
		end else if (use_random) begin
			rnd       = $random(seed);
			out_ready = rnd[0];
		end else begin
			out_ready = 1'b1;
		end
	end

	// Near the end of the output stall a beat must still be held off at the input
	always @(negedge clk) begin
		if (stall_left == 1 && out_valid && in_valid && !in_ready) begin
			saw_in_ready_low = 1'b1;
		end
	end

	////////////////////
	// Table building
	////////////////////

	function automatic tsop_pkg::request_beat_t make_beat(input int a, input int b,
		input int c, input int x, input tsop_pkg::solve_mode_e mode);
		tsop_pkg::request_beat_t beat;
		beat.a    = a[7:0];
		beat.b    = b[7:0];
		beat.c    = c[7:0];
		beat.x    = x[7:0];
		beat.mode = mode;
		beat.last = 1'b0;
		return beat;
	endfunction

	task automatic set_trinomial(input int r, input int a, input int b, input int c,
		input int x, input bit chain);
		row_mode[r]    = tsop_pkg::mode_trinomial;
		row_beat[r][0] = make_beat(a, b, c, x, tsop_pkg::mode_trinomial);
		row_len[r]     = 1;
		row_chain[r]   = chain;
	endtask

	// Appends one pair and moves the last flag onto it
	task automatic add_pair(input int r, input int a, input int x, input bit chain);
		row_mode[r] = tsop_pkg::mode_sum_of_products;
		if (row_len[r] > 0) begin
			row_beat[r][row_len[r]-1].last = 1'b0;
		end
		row_beat[r][row_len[r]]      = make_beat(a, 0, 0, x, tsop_pkg::mode_sum_of_products);
		row_beat[r][row_len[r]].last = 1'b1;
		row_len[r]                   = row_len[r] + 1;
		row_chain[r]                 = chain;
	endtask

	// Horner rule for trinomials, plain sum of a*x for runs, wrapped to 25 bits
	function automatic int expected_of(input int r);
		int                                       full;
		logic signed [tsop_pkg::result_width-1:0] wrapped;
		full = 0;
		if (row_mode[r] == tsop_pkg::mode_trinomial) begin
			full = (int'(row_beat[r][0].a) * int'(row_beat[r][0].x) +
				int'(row_beat[r][0].b)) * int'(row_beat[r][0].x) + int'(row_beat[r][0].c);
		end else begin
			for (int i = 0; i < row_len[r]; i++) begin
				full = full + int'(row_beat[r][i].a) * int'(row_beat[r][i].x);
			end
		end
		wrapped = full[tsop_pkg::result_width-1:0];
		return int'(wrapped);
	endfunction

	task automatic build_table();
		int rnd_a;
		int rnd_x;
		for (int r = 0; r < num_rows; r++) begin
			row_len[r]   = 0;
			row_stall[r] = 1'b0;
		end
		set_trinomial(0, 3, -5, 7, 2, 1'b0);
		set_trinomial(1, -128, 127, -128, 127, 1'b0);
		set_trinomial(2, 127, -128, 127, -128, 1'b0);
		add_pair(3, -7, 9, 1'b0);
		add_pair(4, -128, 127, 1'b0);
		add_pair(4, 127, -128, 1'b0);
		for (int i = 0; i < 16; i++) begin
			rnd_a = $random(seed);
			rnd_x = $random(seed);
			add_pair(5, int'($signed(rnd_a[7:0])), int'($signed(rnd_x[7:0])), 1'b1);
		end
		// Mixed order, a run then a trinomial then a run again
		set_trinomial(6, -3, 4, -100, -9, 1'b1);
		add_pair(7, 5, 6, 1'b1);
		add_pair(7, -2, 7, 1'b1);
		add_pair(7, 100, -100, 1'b0);
		// Short runs fill the result stage fast while the output is stalled
		add_pair(8, 11, -3, 1'b1);
		row_stall[8] = 1'b1;
		add_pair(9, -128, -128, 1'b1);
		add_pair(10, 127, 127, 1'b1);
		set_trinomial(11, -1, -1, -1, -1, 1'b1);
		add_pair(12, 9, 9, 1'b1);
		add_pair(12, -9, 8, 1'b0);
		for (int r = 0; r < num_rows; r++) begin
			row_exp[r] = expected_of(r);
		end
	endtask

	////////////////////
	// Driving
	////////////////////

	// Called half a nanosecond after a rising edge, returns at the same phase
	task automatic send_row(input int r);
		int t;
		for (int i = 0; i < row_len[r] && !timed_out; i++) begin
			in_valid = 1'b1;
			in_beat  = row_beat[r][i];
			t        = 0;
			while (!in_ready && !timed_out) begin
				@(posedge clk);
				#0.5;
				t = t + 1;
				if (t > wait_limit) begin
					$display("Timeout: in_ready stayed low while a beat was offered");
					timed_out = 1'b1;
				end
			end
			if (!timed_out) begin
				@(posedge clk);
				#0.5;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_results(input int target);
		int t;
		t = 0;
		while (checked_count < target && !timed_out) begin
			@(posedge clk);
			#0.5;
			t = t + 1;
			if (t > wait_limit) begin
				$display("Timeout: a result never came out");
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int r;
		int first;
		int got;
		seed             = 32'h3efb44ba;
		clk              = 1'b0;
		reset            = 1'b1;
		in_valid         = 1'b0;
		in_beat          = '0;
		out_ready        = 1'b1;
		stall_left       = 0;
		random_ready     = 1'b0;
		saw_in_ready_low = 1'b0;
		timed_out        = 1'b0;
		table_errors     = 0;
		build_table();
		repeat (16) @(posedge clk);
		#0.5;
		reset = 1'b0;
		// Output must stay quiet until the first request
		repeat (8) begin
			@(posedge clk);
			#0.5;
			if (out_valid) begin
				$display("** Error at %0t: out_valid high before any request", $time);
				table_errors = table_errors + 1;
			end
		end
		r = 0;
		while (r < num_rows && !timed_out) begin
			first = r;
			if (row_stall[r]) begin
				stall_left   = stall_cycles;
				random_ready = 1'b1;
			end
			// A group is a chain of rows sent without waiting for results
			send_row(r);
			while (row_chain[r] && !timed_out) begin
				r = r + 1;
				send_row(r);
			end
			wait_results(r + 1);
			if (!timed_out) begin
				for (int k = first; k <= r; k++) begin
					got = int'(checker0.seen_value[k]);
					if (got != row_exp[k]) begin
						$display("** Error at %0t: table row %0d gave %0d, expected %0d",
							$time, k, got, row_exp[k]);
						table_errors = table_errors + 1;
					end
				end
				if (row_stall[first] && !saw_in_ready_low) begin
					$display("in_ready never dropped while the output was stalled");
					table_errors = table_errors + 1;
				end
			end
			r = r + 1;
		end
		if (!timed_out) begin
			repeat (10) @(posedge clk);
		end
		$display("Checked %0d results, %0d model errors, %0d table errors",
			checked_count, error_count, table_errors);
		if (!timed_out && error_count == 0 && table_errors == 0 &&
			checked_count == num_rows) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
